/* src/fabric_pkg.sv */
// ------------------------------
// memory fabric package
// address map, memory sizes and the
// width types shared by all blocks
// ------------------------------
package fabric_pkg;

  // ------------------------------
  // width types
  // ------------------------------
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0]  strb_t;

  // destination of a request, also the order queue entry
  typedef logic [1:0]  dest_t;

  localparam dest_t DEST_ROM = 2'd0;
  localparam dest_t DEST_RAM = 2'd1;
  localparam dest_t DEST_ERR = 2'd2;

  localparam int unsigned WORD_BYTES = $bits(data_t) / 8;

  // ------------------------------
  // address map
  // ------------------------------
  localparam addr_t       ROM_BASE  = 32'h0001_0000;
  localparam int unsigned ROM_WORDS = 64;

  localparam addr_t       RAM_BASE  = 32'h8000_0000;
  localparam int unsigned RAM_WORDS = 256;

  // upper half of every rom word is this tag plus the word index
  localparam logic [31:0] ROM_TAG = 32'hB007_0000;

  // requests that may wait for a response at the same time
  localparam int unsigned ORDER_DEPTH = 4;

endpackage

/* src/req_router.sv */
// ------------------------------
// request router
// decodes the address of each request and
// steers it to the rom, the ram or the error path
// ------------------------------
`timescale 1ns/1ps

module req_router (
  input  logic              req_valid_i,
  input  logic              req_we_i,
  input  fabric_pkg::addr_t req_addr_i,
  input  fabric_pkg::strb_t req_be_i,
  input  fabric_pkg::data_t req_wdata_i,
  output logic              req_ready_o,

  output logic              rom_req_valid_o,
  input  logic              rom_req_ready_i,
  output logic              ram_req_valid_o,
  input  logic              ram_req_ready_i,

  output logic              slv_we_o,
  output fabric_pkg::addr_t slv_addr_o,
  output fabric_pkg::strb_t slv_be_o,
  output fabric_pkg::data_t slv_wdata_o,

  output logic              tag_valid_o,
  output fabric_pkg::dest_t tag_o,
  input  logic              tag_ready_i
);

  import fabric_pkg::*;

  // end addresses, excluded from their region
  localparam addr_t ROM_END = ROM_BASE + addr_t'(ROM_WORDS * WORD_BYTES);
  localparam addr_t RAM_END = RAM_BASE + addr_t'(RAM_WORDS * WORD_BYTES);

  dest_t dest;
  logic  slv_ready;

  // ------------------------------
  // address decode
  // ------------------------------
  always_comb begin
    if (req_addr_i >= ROM_BASE && req_addr_i < ROM_END) begin
      dest = DEST_ROM;
    end else if (req_addr_i >= RAM_BASE && req_addr_i < RAM_END) begin
      dest = DEST_RAM;
    end else begin
      dest = DEST_ERR;
    end
  end

  // error path needs no slave
  always_comb begin
    case (dest)
      DEST_ROM: slv_ready = rom_req_ready_i;
      DEST_RAM: slv_ready = ram_req_ready_i;
      default:  slv_ready = 1'b1;
    endcase
  end

  // ------------------------------
  // handshakes
  // ------------------------------
  // slave and order queue take the request in the same transfer
  assign req_ready_o     = tag_ready_i && slv_ready;
  assign rom_req_valid_o = req_valid_i && tag_ready_i && (dest == DEST_ROM);
  assign ram_req_valid_o = req_valid_i && tag_ready_i && (dest == DEST_RAM);

  assign tag_valid_o = req_valid_i && slv_ready;
  assign tag_o       = dest;

  // shared request payload
  assign slv_we_o    = req_we_i;
  assign slv_addr_o  = req_addr_i;
  assign slv_be_o    = req_be_i;
  assign slv_wdata_o = req_wdata_i;

endmodule

/* src/boot_rom.sv */
// ------------------------------
// boot rom
// fixed pattern content, one registered
// response, writes answered with an error
// ------------------------------
`timescale 1ns/1ps

module boot_rom (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  logic              req_we_i,
  input  fabric_pkg::addr_t req_addr_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output fabric_pkg::data_t rsp_rdata_o,
  output logic              rsp_err_o,
  input  logic              rsp_ready_i
);

  import fabric_pkg::*;

  localparam int unsigned IDX_W = $clog2(ROM_WORDS);
  localparam int unsigned OFS_W = $clog2(WORD_BYTES);

  addr_t            offset;
  logic [IDX_W-1:0] word_idx;
  logic             accept;

  logic  rsp_valid_q;
  data_t rsp_rdata_q;
  logic  rsp_err_q;

  // tag plus index on top, inverted index below
  function automatic data_t rom_word(input logic [IDX_W-1:0] idx);
    logic [31:0] idx32;
    idx32 = 32'(idx);
    return {ROM_TAG + idx32, ~idx32};
  endfunction

  assign offset   = req_addr_i - ROM_BASE;
  assign word_idx = IDX_W'(offset >> OFS_W);

  // register free or emptied this cycle
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_rdata_q <= req_we_i ? '0 : rom_word(word_idx);
      rsp_err_q   <= req_we_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;

endmodule

/* src/sram_bank.sv */
// ------------------------------
// ram bank
// byte enabled word storage with
// one registered response
// ------------------------------
`timescale 1ns/1ps

module sram_bank (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  logic              req_we_i,
  input  fabric_pkg::addr_t req_addr_i,
  input  fabric_pkg::strb_t req_be_i,
  input  fabric_pkg::data_t req_wdata_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output fabric_pkg::data_t rsp_rdata_o,
  input  logic              rsp_ready_i
);

  import fabric_pkg::*;

  localparam int unsigned IDX_W = $clog2(RAM_WORDS);
  localparam int unsigned OFS_W = $clog2(WORD_BYTES);

  data_t mem_q [RAM_WORDS];

  addr_t            offset;
  logic [IDX_W-1:0] word_idx;
  logic             accept;

  logic  rsp_valid_q;
  data_t rsp_rdata_q;

  assign offset   = req_addr_i - RAM_BASE;
  assign word_idx = IDX_W'(offset >> OFS_W);

  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  // ------------------------------
  // storage
  // ------------------------------
  // only enabled bytes change
  always_ff @(posedge clk_i) begin
    if (accept && req_we_i) begin
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (req_be_i[b]) begin
          mem_q[word_idx][b*8 +: 8] <= req_wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // ------------------------------
  // response register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_rdata_q <= req_we_i ? '0 : mem_q[word_idx];
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;

endmodule

/* src/rsp_merge.sv */
// ------------------------------
// response merger
// keeps the order of requests in flight and
// merges slave responses and decode errors
// ------------------------------
`timescale 1ns/1ps

module rsp_merge (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              tag_valid_i,
  input  fabric_pkg::dest_t tag_i,
  output logic              tag_ready_o,

  input  logic              rom_rsp_valid_i,
  input  fabric_pkg::data_t rom_rsp_rdata_i,
  input  logic              rom_rsp_err_i,
  output logic              rom_rsp_ready_o,

  input  logic              ram_rsp_valid_i,
  input  fabric_pkg::data_t ram_rsp_rdata_i,
  output logic              ram_rsp_ready_o,

  output logic              rsp_valid_o,
  output fabric_pkg::data_t rsp_rdata_o,
  output logic              rsp_err_o,
  input  logic              rsp_ready_i
);

  import fabric_pkg::*;

  localparam int unsigned PTR_W = $clog2(ORDER_DEPTH);

  // ------------------------------
  // order queue
  // ------------------------------
  dest_t order_q [ORDER_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;

  logic  push;
  logic  pop;
  logic  head_valid;
  dest_t head;

  assign tag_ready_o = (count_q != (PTR_W+1)'(ORDER_DEPTH));
  assign push        = tag_valid_i && tag_ready_o;
  assign pop         = rsp_valid_o && rsp_ready_i;

  assign head_valid = (count_q != '0);
  assign head       = order_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr_q] <= tag_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(ORDER_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(ORDER_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // ------------------------------
  // head select
  // ------------------------------
  // only the source at the head sees the ready
  assign rom_rsp_ready_o = head_valid && (head == DEST_ROM) && rsp_ready_i;
  assign ram_rsp_ready_o = head_valid && (head == DEST_RAM) && rsp_ready_i;

  always_comb begin
    rsp_valid_o = 1'b0;
    rsp_rdata_o = '0;
    rsp_err_o   = 1'b0;
    if (head_valid) begin
      case (head)
        DEST_ROM: begin
          rsp_valid_o = rom_rsp_valid_i;
          rsp_rdata_o = rom_rsp_rdata_i;
          rsp_err_o   = rom_rsp_err_i;
        end
        DEST_RAM: begin
          rsp_valid_o = ram_rsp_valid_i;
          rsp_rdata_o = ram_rsp_rdata_i;
        end
        // decode error straight from the queue
        default: begin
          rsp_valid_o = 1'b1;
          rsp_err_o   = 1'b1;
        end
      endcase
    end
  end

endmodule

/* src/mem_fabric_top.sv */
// ------------------------------
// memory fabric top level
// router, boot rom, ram bank and
// in-order response merger
// ------------------------------
`timescale 1ns/1ps

module mem_fabric_top (
  input  logic              clk_i,
  input  logic              rst_ni,

  input  logic              req_valid_i,
  input  logic              req_we_i,
  input  fabric_pkg::addr_t req_addr_i,
  input  fabric_pkg::strb_t req_be_i,
  input  fabric_pkg::data_t req_wdata_i,
  output logic              req_ready_o,

  output logic              rsp_valid_o,
  output fabric_pkg::data_t rsp_rdata_o,
  output logic              rsp_err_o,
  input  logic              rsp_ready_i
);

  import fabric_pkg::*;

  // router to slaves
  logic  rom_req_valid;
  logic  rom_req_ready;
  logic  ram_req_valid;
  logic  ram_req_ready;
  logic  slv_we;
  addr_t slv_addr;
  strb_t slv_be;
  data_t slv_wdata;

  // router to merger
  logic  tag_valid;
  dest_t tag;
  logic  tag_ready;

  // slaves to merger
  logic  rom_rsp_valid;
  data_t rom_rsp_rdata;
  logic  rom_rsp_err;
  logic  rom_rsp_ready;
  logic  ram_rsp_valid;
  data_t ram_rsp_rdata;
  logic  ram_rsp_ready;

  req_router req_router_inst (
    .req_valid_i     (req_valid_i),
    .req_we_i        (req_we_i),
    .req_addr_i      (req_addr_i),
    .req_be_i        (req_be_i),
    .req_wdata_i     (req_wdata_i),
    .req_ready_o     (req_ready_o),
    .rom_req_valid_o (rom_req_valid),
    .rom_req_ready_i (rom_req_ready),
    .ram_req_valid_o (ram_req_valid),
    .ram_req_ready_i (ram_req_ready),
    .slv_we_o        (slv_we),
    .slv_addr_o      (slv_addr),
    .slv_be_o        (slv_be),
    .slv_wdata_o     (slv_wdata),
    .tag_valid_o     (tag_valid),
    .tag_o           (tag),
    .tag_ready_i     (tag_ready)
  );

  boot_rom boot_rom_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (rom_req_valid),
    .req_we_i    (slv_we),
    .req_addr_i  (slv_addr),
    .req_ready_o (rom_req_ready),
    .rsp_valid_o (rom_rsp_valid),
    .rsp_rdata_o (rom_rsp_rdata),
    .rsp_err_o   (rom_rsp_err),
    .rsp_ready_i (rom_rsp_ready)
  );

  sram_bank sram_bank_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (ram_req_valid),
    .req_we_i    (slv_we),
    .req_addr_i  (slv_addr),
    .req_be_i    (slv_be),
    .req_wdata_i (slv_wdata),
    .req_ready_o (ram_req_ready),
    .rsp_valid_o (ram_rsp_valid),
    .rsp_rdata_o (ram_rsp_rdata),
    .rsp_ready_i (ram_rsp_ready)
  );

  rsp_merge rsp_merge_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .tag_valid_i     (tag_valid),
    .tag_i           (tag),
    .tag_ready_o     (tag_ready),
    .rom_rsp_valid_i (rom_rsp_valid),
    .rom_rsp_rdata_i (rom_rsp_rdata),
    .rom_rsp_err_i   (rom_rsp_err),
    .rom_rsp_ready_o (rom_rsp_ready),
    .ram_rsp_valid_i (ram_rsp_valid),
    .ram_rsp_rdata_i (ram_rsp_rdata),
    .ram_rsp_ready_o (ram_rsp_ready),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_rdata_o     (rsp_rdata_o),
    .rsp_err_o       (rsp_err_o),
    .rsp_ready_i     (rsp_ready_i)
  );

endmodule

/* bench/mem_fabric_asserts.sv */
// ------------------------------
// memory fabric assertions
// handshake rules on the top level ports
// ------------------------------
`timescale 1ns/1ps

module mem_fabric_asserts (
  input logic              clk_i,
  input logic              rst_ni,
  input logic              req_valid_i,
  input logic              req_ready_i,
  input fabric_pkg::addr_t req_addr_i,
  input logic              rsp_valid_i,
  input fabric_pkg::data_t rsp_rdata_i,
  input logic              rsp_err_i,
  input logic              rsp_ready_i
);

  // response held until taken
  rsp_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i) && $stable(rsp_err_i)
  ) else $error("response dropped or changed before it was taken");

  // stimulus side, request held until taken
  req_hold: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_addr_i)
  ) else $error("request dropped or address changed before it was taken");

  rsp_in_reset: assert property (
    @(posedge clk_i) !rst_ni |-> !rsp_valid_i
  ) else $error("response valid while in reset");

endmodule

bind mem_fabric_top mem_fabric_asserts mem_fabric_asserts_inst (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .req_valid_i (req_valid_i),
  .req_ready_i (req_ready_o),
  .req_addr_i  (req_addr_i),
  .rsp_valid_i (rsp_valid_o),
  .rsp_rdata_i (rsp_rdata_o),
  .rsp_err_i   (rsp_err_o),
  .rsp_ready_i (rsp_ready_i)
);

/* bench/tb_mem_fabric.sv */
// ------------------------------
// memory fabric testbench
// directed and random traffic checked
// against a model of the address map
// ------------------------------
`timescale 1ns/1ps

module tb_mem_fabric;

  import fabric_pkg::*;

  // longest run is a little over 1000 cycles
  localparam int unsigned TIMEOUT_CYCLES = 5000;
  localparam int unsigned RANDOM_REQS    = 200;
  localparam addr_t ROM_END = ROM_BASE + addr_t'(ROM_WORDS * WORD_BYTES);
  localparam addr_t RAM_END = RAM_BASE + addr_t'(RAM_WORDS * WORD_BYTES);

  logic  clk_i;
  logic  rst_ni;
  logic  req_valid_i;
  logic  req_we_i;
  addr_t req_addr_i;
  strb_t req_be_i;
  data_t req_wdata_i;
  logic  req_ready_o;
  logic  rsp_valid_o;
  data_t rsp_rdata_o;
  logic  rsp_err_o;
  logic  rsp_ready_i;

  data_t       ref_ram [RAM_WORDS];
  logic [64:0] exp_q [$];
  int unsigned acc_cyc_q [$];
  int unsigned cyc;
  int unsigned last_latency;
  int unsigned err_count;
  int unsigned test_err_start;
  int unsigned tests_run;
  int unsigned tests_failed;
  int unsigned n_req;
  int unsigned n_rsp;
  logic        stim_done;
  string       cur_test;

  mem_fabric_top mem_fabric_top_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (req_valid_i),
    .req_we_i    (req_we_i),
    .req_addr_i  (req_addr_i),
    .req_be_i    (req_be_i),
    .req_wdata_i (req_wdata_i),
    .req_ready_o (req_ready_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o),
    .rsp_ready_i (rsp_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles with %0d responses missing",
               cyc, exp_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------
  // returns {err, rdata}; ram writes also update the model
  function automatic logic [64:0] expected_rsp(input logic we, input addr_t addr,
                                               input strb_t be, input data_t wdata);
    logic [31:0] idx;
    if (addr >= ROM_BASE && addr < ROM_END) begin
      idx = (addr - ROM_BASE) / WORD_BYTES;
      if (we) begin
        return {1'b1, 64'd0};
      end
      return {1'b0, ROM_TAG + idx, ~idx};
    end
    if (addr >= RAM_BASE && addr < RAM_END) begin
      idx = (addr - RAM_BASE) / WORD_BYTES;
      if (!we) begin
        return {1'b0, ref_ram[idx]};
      end
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (be[b]) begin
          ref_ram[idx][b*8 +: 8] = wdata[b*8 +: 8];
        end
      end
      return {1'b0, 64'd0};
    end
    return {1'b1, 64'd0};
  endfunction

  // random address, low offset bits included
  function automatic addr_t rand_addr(input dest_t dest);
    case (dest)
      DEST_ROM: return ROM_BASE + addr_t'($urandom_range(ROM_WORDS * WORD_BYTES - 1, 0));
      DEST_RAM: return RAM_BASE + addr_t'($urandom_range(RAM_WORDS * WORD_BYTES - 1, 0));
      default: begin
        case ($urandom_range(2, 0))
          0:       return addr_t'($urandom_range(ROM_BASE - 1, 0));
          1:       return ROM_END + addr_t'($urandom_range(32'hFFF, 0));
          default: return RAM_END + addr_t'($urandom_range(32'hFFFF, 0));
        endcase
      end
    endcase
  endfunction

  task automatic check(input string name, input data_t expected, input data_t actual);
    if (expected !== actual) begin
      err_count++;
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // compare process, sampled mid cycle where all signals are settled
  always @(negedge clk_i) begin
    logic [64:0] exp;
    if (rst_ni) begin
      if (rsp_valid_o && rsp_ready_i) begin
        n_rsp++;
        if (exp_q.size() == 0) begin
          err_count++;
          $display("response arrived with no request outstanding in test %s", cur_test);
        end else begin
          exp = exp_q.pop_front();
          last_latency = cyc - acc_cyc_q.pop_front();
          check({cur_test, " rdata"}, exp[63:0], rsp_rdata_o);
          check({cur_test, " err"}, 64'(exp[64]), 64'(rsp_err_o));
        end
      end
      if (req_valid_i && req_ready_o) begin
        n_req++;
        exp_q.push_back(expected_rsp(req_we_i, req_addr_i, req_be_i, req_wdata_i));
        acc_cyc_q.push_back(cyc);
      end
    end
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  // called 1 ns after a rising edge, returns at the same phase
  task automatic issue(input logic we, input addr_t addr, input strb_t be,
                       input data_t wdata);
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_be_i    = be;
    req_wdata_i = wdata;
    do begin
      @(negedge clk_i);
    end while (!req_ready_o);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test       = name;
    test_err_start = err_count;
  endtask

  task automatic end_test();
    wait_drain();
    // a few quiet cycles so a stray response shows up here
    repeat (3) @(posedge clk_i);
    #1;
    tests_run++;
    if (err_count == test_err_start) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, err_count - test_err_start);
    end
  endtask

  task automatic random_requests();
    addr_t a;
    for (int n = 0; n < RANDOM_REQS; n++) begin
      if ($urandom_range(3, 0) == 0) begin
        repeat ($urandom_range(3, 1)) @(posedge clk_i);
        #1;
      end
      a = rand_addr(dest_t'($urandom_range(2, 0)));
      issue(1'($urandom_range(1, 0)), a, strb_t'($urandom), {$urandom, $urandom});
    end
    stim_done = 1'b1;
  endtask

  task automatic random_ready();
    while (!stim_done) begin
      @(posedge clk_i);
      #1;
      rsp_ready_i = ($urandom_range(3, 0) != 0);
    end
    rsp_ready_i = 1'b1;
  endtask

  initial begin
    addr_t a;
    void'($urandom(25997));
    {err_count, tests_run, tests_failed, n_req, n_rsp} = '0;
    last_latency = 0;
    stim_done    = 1'b0;
    cur_test     = "reset";
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_we_i     = 1'b0;
    req_addr_i   = '0;
    req_be_i     = '0;
    req_wdata_i  = '0;
    rsp_ready_i  = 1'b1;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    begin_test("reset");
    check("reset rsp_valid", '0, 64'(rsp_valid_o));
    end_test();

    begin_test("rom_read");
    issue(1'b0, ROM_BASE, '1, '0);
    issue(1'b0, ROM_END - addr_t'(WORD_BYTES), '1, '0);
    repeat (8) issue(1'b0, rand_addr(DEST_ROM), '1, '0);
    end_test();

    // fill word depends on the whole address
    begin_test("ram_fill");
    for (int i = 0; i < RAM_WORDS; i++) begin
      a = RAM_BASE + addr_t'(i * WORD_BYTES);
      issue(1'b1, a, '1, {a ^ 32'hC3C3_3C3C, ~a});
    end
    for (int i = 0; i < RAM_WORDS; i += 17) begin
      issue(1'b0, RAM_BASE + addr_t'(i * WORD_BYTES), '0, '0);
    end
    end_test();

    begin_test("ram_byte_en");
    repeat (16) begin
      a = rand_addr(DEST_RAM);
      issue(1'b1, a, strb_t'($urandom), {$urandom, $urandom});
      issue(1'b0, a, '0, '0);
    end
    end_test();

    begin_test("error_paths");
    issue(1'b0, ROM_BASE - 32'd8, '1, '0);
    issue(1'b1, ROM_END, '1, '1);
    issue(1'b0, ROM_END + 32'd8, '1, '0);
    repeat (6) issue(1'($urandom_range(1, 0)), rand_addr(DEST_ERR), '1, {$urandom, $urandom});
    a = ROM_BASE + 32'd40;
    issue(1'b1, a, '1, '1);
    issue(1'b0, a, '1, '0);
    end_test();

    begin_test("latency");
    issue(1'b0, rand_addr(DEST_ROM), '1, '0);
    wait_drain();
    check("latency rom", 64'd1, 64'(last_latency));
    issue(1'b0, rand_addr(DEST_RAM), '1, '0);
    wait_drain();
    check("latency ram", 64'd1, 64'(last_latency));
    issue(1'b0, rand_addr(DEST_ERR), '1, '0);
    wait_drain();
    check("latency err", 64'd1, 64'(last_latency));
    end_test();

    begin_test("random_mix");
    n_req = 0;
    n_rsp = 0;
    fork
      random_requests();
      random_ready();
    join
    wait_drain();
    // late or repeated responses must not add to the count
    repeat (3) @(posedge clk_i);
    #1;
    check("random_mix responses", 64'(RANDOM_REQS), 64'(n_rsp));
    end_test();

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* verilog.f */
src/fabric_pkg.sv
src/req_router.sv
src/boot_rom.sv
src/sram_bank.sv
src/rsp_merge.sv
src/mem_fabric_top.sv
bench/mem_fabric_asserts.sv
bench/tb_mem_fabric.sv

/* Makefile */
# Verilator build and run for the memory fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_fabric
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "TB PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
